/* common/cordic_consts.svh */
`ifndef CORDIC_CONSTS_SVH
`define CORDIC_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////

// signed coordinate, two integer bits and sixteen fraction bits
`define CORDIC_COORD_W 18
`define CORDIC_FRAC_W 16

// binary angle, full circle is 2^16 units
`define CORDIC_ANGLE_W 16

////////////////////////////////////////////////////////////////////////////
// iteration control
////////////////////////////////////////////////////////////////////////////

`define CORDIC_ITER 16
`define CORDIC_CNT_W 4

// start values, scaled by 2^CORDIC_FRAC_W
`define CORDIC_INV_GAIN 39797
`define CORDIC_ONE (1 << `CORDIC_FRAC_W)

`endif

/* common/cordic_pkg.sv */
`include "cordic_consts.svh"

package cordic_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // scalar types
    ////////////////////////////////////////////////////////////////////////////

    // fixed point coordinate, range -2 to 2
    typedef logic signed [`CORDIC_COORD_W-1:0] coord_t;

    // binary angle, wraps modulo a full circle
    typedef logic [`CORDIC_ANGLE_W-1:0] angle_t;

    typedef logic [`CORDIC_CNT_W-1:0] iter_t;

    // top two bits of a binary angle
    typedef logic [1:0] quadrant_t;

    typedef enum logic {
        CORDIC_ROTATE,
        CORDIC_VECTOR
    } cordic_mode_e;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_FINISH
    } seq_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////////////////////

    // working vector of the iteration
    typedef struct packed {
        coord_t x;
        coord_t y;
        angle_t z;
    } cordic_vec_t;

    // angle is used in rotate mode, y in vector mode
    typedef struct packed {
        cordic_mode_e mode;
        angle_t       angle;
        coord_t       y;
    } cordic_req_t;

    typedef struct packed {
        coord_t sin;
        coord_t cos;
        angle_t angle;
    } cordic_res_t;

endpackage

/* cordic_core/cordic_atan_rom.sv */
`timescale 1ns/1ps

module cordic_atan_rom (
    input  cordic_pkg::iter_t  iter_i,
    output cordic_pkg::angle_t step_o
);
    import cordic_pkg::*;

    // atan(2^-i) in binary-angle units, 65536 per full circle
    always_comb begin
        unique case (iter_i)
            4'd0:  step_o = angle_t'(8192);
            4'd1:  step_o = angle_t'(4836);
            4'd2:  step_o = angle_t'(2555);
            4'd3:  step_o = angle_t'(1297);
            4'd4:  step_o = angle_t'(651);
            4'd5:  step_o = angle_t'(326);
            4'd6:  step_o = angle_t'(163);
            4'd7:  step_o = angle_t'(81);
            4'd8:  step_o = angle_t'(41);
            4'd9:  step_o = angle_t'(20);
            4'd10: step_o = angle_t'(10);
            4'd11: step_o = angle_t'(5);
            4'd12: step_o = angle_t'(3);
            4'd13: step_o = angle_t'(1);
            4'd14: step_o = angle_t'(1);
            // below one unit of resolution
            4'd15: step_o = angle_t'(0);
        endcase
    end

endmodule

/* cordic_core/cordic_micro_rotation.sv */
`timescale 1ns/1ps

`include "cordic_consts.svh"

module cordic_micro_rotation (
    input  cordic_pkg::cordic_vec_t  vec_i,
    input  cordic_pkg::iter_t        iter_i,
    input  cordic_pkg::angle_t       step_i,
    input  cordic_pkg::cordic_mode_e mode_i,
    output cordic_pkg::cordic_vec_t  vec_o
);
    import cordic_pkg::*;

    logic   rot_ccw;
    coord_t x_cur;
    coord_t y_cur;
    coord_t x_shift;
    coord_t y_shift;

    ////////////////////////////////////////////////////////////////////////////
    // direction decision
    ////////////////////////////////////////////////////////////////////////////

    // rotate mode drives z to zero, vector mode drives y to zero
    always_comb begin
        if (mode_i == CORDIC_ROTATE) begin
            // z read as a signed angle
            rot_ccw = ~vec_i.z[`CORDIC_ANGLE_W-1];
        end else begin
            rot_ccw = vec_i.y[`CORDIC_COORD_W-1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // shift and add
    ////////////////////////////////////////////////////////////////////////////

    assign x_cur = vec_i.x;
    assign y_cur = vec_i.y;

    // arithmetic shift, truncating toward minus infinity
    assign x_shift = x_cur >>> iter_i;
    assign y_shift = y_cur >>> iter_i;

    always_comb begin
        if (rot_ccw) begin
            vec_o.x = x_cur - y_shift;
            vec_o.y = y_cur + x_shift;
            vec_o.z = vec_i.z - step_i;
        end else begin
            vec_o.x = x_cur + y_shift;
            vec_o.y = y_cur - x_shift;
            vec_o.z = vec_i.z + step_i;
        end
    end

endmodule

/* cordic_core/cordic_sequencer.sv */
`timescale 1ns/1ps

`include "cordic_consts.svh"

module cordic_sequencer (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     start_i,
    input  cordic_pkg::cordic_mode_e mode_i,
    input  cordic_pkg::cordic_vec_t  start_vec_i,
    input  cordic_pkg::quadrant_t    quadrant_i,
    output logic                     busy_o,
    output logic                     done_o,
    output cordic_pkg::cordic_vec_t  vec_o,
    output cordic_pkg::quadrant_t    quadrant_o
);
    import cordic_pkg::*;

    localparam iter_t LAST_ITER = iter_t'(`CORDIC_ITER - 1);

    seq_state_e   state_q;
    iter_t        cnt_q;
    cordic_mode_e mode_q;
    quadrant_t    quad_q;
    cordic_vec_t  vec_q;
    angle_t       step;
    cordic_vec_t  next_vec;

    ////////////////////////////////////////////////////////////////////////////
    // one iteration step
    ////////////////////////////////////////////////////////////////////////////

    cordic_atan_rom i_cordic_atan_rom (
        .iter_i (cnt_q),
        .step_o (step)
    );

    cordic_micro_rotation i_cordic_micro_rotation (
        .vec_i  (vec_q),
        .iter_i (cnt_q),
        .step_i (step),
        .mode_i (mode_q),
        .vec_o  (next_vec)
    );

    ////////////////////////////////////////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////////////////////////////////////////

    // state, counter and the latched request
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= SEQ_IDLE;
            cnt_q   <= '0;
            mode_q  <= CORDIC_ROTATE;
            quad_q  <= '0;
            vec_q   <= '0;
        end else begin
            unique case (state_q)
                SEQ_IDLE, SEQ_FINISH: begin
                    // busy is low in both states, so a strobe is taken
                    if (start_i) begin
                        vec_q   <= start_vec_i;
                        mode_q  <= mode_i;
                        quad_q  <= quadrant_i;
                        cnt_q   <= '0;
                        state_q <= SEQ_RUN;
                    end else begin
                        state_q <= SEQ_IDLE;
                    end
                end
                SEQ_RUN: begin
                    vec_q <= next_vec;
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == LAST_ITER) begin
                        state_q <= SEQ_FINISH;
                    end
                end
                default: begin
                    state_q <= SEQ_IDLE;
                end
            endcase
        end
    end

    assign busy_o     = (state_q == SEQ_RUN);
    assign done_o     = (state_q == SEQ_FINISH);
    assign vec_o      = vec_q;
    assign quadrant_o = quad_q;

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // finish is left on the next edge
    a_done_single: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        done_o |=> !done_o
    ) else $error("done pulse longer than one cycle");

    // strobe during run leaves the item in flight untouched
    a_start_ignored: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (state_q == SEQ_RUN && start_i) |=>
            $stable(mode_q) && $stable(quad_q) &&
            (cnt_q == iter_t'($past(cnt_q) + 1'b1))
    ) else $error("start acted on while running");

endmodule

/* src/cordic_quadrant_map.sv */
`timescale 1ns/1ps

`include "cordic_consts.svh"

module cordic_quadrant_map (
    input  cordic_pkg::cordic_req_t req_i,
    output cordic_pkg::cordic_vec_t start_vec_o,
    output cordic_pkg::quadrant_t   quadrant_o,
    input  cordic_pkg::cordic_vec_t final_vec_i,
    input  cordic_pkg::quadrant_t   quadrant_i,
    output cordic_pkg::cordic_res_t res_o
);
    import cordic_pkg::*;

    coord_t req_y;
    coord_t fin_c;
    coord_t fin_s;

    ////////////////////////////////////////////////////////////////////////////
    // fold path
    ////////////////////////////////////////////////////////////////////////////

    assign req_y = req_i.y;

    always_comb begin
        if (req_i.mode == CORDIC_ROTATE) begin
            // quadrant from the two top bits, rest lies in [0, 90) degrees
            quadrant_o    = req_i.angle[`CORDIC_ANGLE_W-1 -: 2];
            start_vec_o.x = coord_t'(`CORDIC_INV_GAIN);
            start_vec_o.y = '0;
            start_vec_o.z = {2'b00, req_i.angle[`CORDIC_ANGLE_W-3:0]};
        end else begin
            quadrant_o    = '0;
            // half scale keeps the grown x, up to 1.65 * sqrt(2),
            // inside the coordinate range; the angle does not change
            start_vec_o.x = coord_t'(`CORDIC_ONE / 2);
            start_vec_o.y = req_y >>> 1;
            start_vec_o.z = '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // unfold path
    ////////////////////////////////////////////////////////////////////////////

    // first-quadrant cos and sin
    assign fin_c = final_vec_i.x;
    assign fin_s = final_vec_i.y;

    always_comb begin
        res_o.angle = final_vec_i.z;
        unique case (quadrant_i)
            2'd0: begin
                res_o.cos = fin_c;
                res_o.sin = fin_s;
            end
            // plus 90 degrees
            2'd1: begin
                res_o.cos = -fin_s;
                res_o.sin = fin_c;
            end
            2'd2: begin
                res_o.cos = -fin_c;
                res_o.sin = -fin_s;
            end
            2'd3: begin
                res_o.cos = fin_s;
                res_o.sin = -fin_c;
            end
        endcase
    end

endmodule

/* src/cordic_top.sv */
`timescale 1ns/1ps

module cordic_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    start_i,
    input  cordic_pkg::cordic_req_t req_i,
    output logic                    busy_o,
    output logic                    done_o,
    output cordic_pkg::cordic_res_t res_o
);

    // folded start of the request
    cordic_pkg::cordic_vec_t start_vec;
    cordic_pkg::quadrant_t   start_quad;

    // vector and quadrant held by the sequencer
    cordic_pkg::cordic_vec_t final_vec;
    cordic_pkg::quadrant_t   final_quad;

    ////////////////////////////////////////////////////////////////////////////
    // quadrant folding and result casting
    ////////////////////////////////////////////////////////////////////////////

    cordic_quadrant_map i_cordic_quadrant_map (
        .req_i       (req_i),
        .start_vec_o (start_vec),
        .quadrant_o  (start_quad),
        .final_vec_i (final_vec),
        .quadrant_i  (final_quad),
        .res_o       (res_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // iteration engine
    ////////////////////////////////////////////////////////////////////////////

    cordic_sequencer i_cordic_sequencer (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .start_i     (start_i),
        .mode_i      (req_i.mode),
        .start_vec_i (start_vec),
        .quadrant_i  (start_quad),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .vec_o       (final_vec),
        .quadrant_o  (final_quad)
    );

endmodule

/* verification/cordic_tb_vectors.svh */
`ifndef CORDIC_TB_VECTORS_SVH
`define CORDIC_TB_VECTORS_SVH

// columns: mode, arg, expected sin, expected cos, expected angle
// arg is the binary angle in rotate mode and y in vector mode
// rotate rows leave the angle column at zero, vector rows the cos column
// expected values are round(true value * 2^16), sin/cos 18 bit two's complement
task automatic load_vectors();
    // rotation over all four quadrants
    vectors[0]  = '{CORDIC_ROTATE, 18'h00000, 18'h00000, 18'h10000, 16'h0000};
    vectors[1]  = '{CORDIC_ROTATE, 18'h02000, 18'h0B505, 18'h0B505, 16'h0000};
    vectors[2]  = '{CORDIC_ROTATE, 18'h04000, 18'h10000, 18'h00000, 16'h0000};
    vectors[3]  = '{CORDIC_ROTATE, 18'h06000, 18'h0B505, 18'h34AFB, 16'h0000};
    vectors[4]  = '{CORDIC_ROTATE, 18'h08000, 18'h00000, 18'h30000, 16'h0000};
    vectors[5]  = '{CORDIC_ROTATE, 18'h0C000, 18'h30000, 18'h00000, 16'h0000};
    // 0xD555 is 299.998 degrees
    vectors[6]  = '{CORDIC_ROTATE, 18'h0D555, 18'h3224B, 18'h07FFE, 16'h0000};

    // vectoring, y of 0.25, 0.5, -0.5, 1.0 and -1.0
    vectors[7]  = '{CORDIC_VECTOR, 18'h04000, 18'h00000, 18'h00000, 16'h09FB};
    vectors[8]  = '{CORDIC_VECTOR, 18'h08000, 18'h00000, 18'h00000, 16'h12E4};
    vectors[9]  = '{CORDIC_VECTOR, 18'h38000, 18'h00000, 18'h00000, 16'hED1C};
    vectors[10] = '{CORDIC_VECTOR, 18'h10000, 18'h00000, 18'h00000, 16'h2000};
    vectors[11] = '{CORDIC_VECTOR, 18'h30000, 18'h00000, 18'h00000, 16'hE000};
endtask

`endif

/* verification/cordic_tb.sv */
`timescale 1ns/1ps

`include "cordic_consts.svh"

module cordic_tb;
    import cordic_pkg::*;

    // arg is the angle in rotate mode and y in vector mode
    typedef struct packed {
        cordic_mode_e mode;
        coord_t       arg;
        coord_t       exp_sin;
        coord_t       exp_cos;
        angle_t       exp_angle;
    } vec_entry_t;

    localparam int NUM_VECTORS = 12;
    localparam int DONE_LAT    = `CORDIC_ITER + 1;
    localparam int COORD_TOL   = 12;
    localparam int ANGLE_TOL   = 8;
    localparam int MAX_GAP     = 5;
    localparam int STRAY_ENTRY = 1;
    localparam int STRAY_CYCLE = 5;
    // reset, then per entry start, latency, one idle cycle and the largest gap
    localparam int CYCLE_LIMIT = 8 + NUM_VECTORS * 24;

    logic        clk;
    logic        rst_n_i;
    logic        start_i;
    cordic_req_t req_i;
    logic        busy_o;
    logic        done_o;
    cordic_res_t res_o;

    vec_entry_t vectors [NUM_VECTORS];
    int         cycle_cnt;

    `include "cordic_tb_vectors.svh"

    cordic_top i_cordic_top (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .start_i (start_i),
        .req_i   (req_i),
        .busy_o  (busy_o),
        .done_o  (done_o),
        .res_o   (res_o)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", reason);
    endtask

    function automatic cordic_req_t make_req(input vec_entry_t entry);
        cordic_req_t req;
        req.mode  = entry.mode;
        req.angle = entry.arg[`CORDIC_ANGLE_W-1:0];
        req.y     = entry.arg;
        return req;
    endfunction

    task automatic check_coord(input string name, input coord_t actual, input coord_t expected);
        int err;
        err = int'(actual) - int'(expected);
        if (err < 0) begin
            err = -err;
        end
        assert (err <= COORD_TOL)
            else begin
                $display("CHECK FAILED: %s expected 0x%h got 0x%h", name, expected, actual);
                abort_run("coordinate outside tolerance");
            end
    endtask

    // difference taken modulo a full circle
    task automatic check_angle(input string name, input angle_t actual, input angle_t expected);
        logic signed [`CORDIC_ANGLE_W-1:0] delta;
        int                                err;
        delta = actual - expected;
        err   = int'(delta);
        if (err < 0) begin
            err = -err;
        end
        assert (err <= ANGLE_TOL)
            else begin
                $display("CHECK FAILED: %s expected 0x%h got 0x%h", name, expected, actual);
                abort_run("angle outside tolerance");
            end
    endtask

    // one idle cycle, no done, no busy, result held
    task automatic check_idle(input cordic_res_t held);
        @(posedge clk);
        @(negedge clk);
        assert (!done_o && !busy_o)
            else begin
                $display("ERROR: done_o or busy_o high while no request is in flight");
                abort_run("unexpected done or busy");
            end
        assert (res_o == held)
            else begin
                $display("CHECK FAILED: res_o expected 0x%h got 0x%h", held, res_o);
                abort_run("result not held");
            end
    endtask

    task automatic apply_entry(input int idx);
        vec_entry_t  entry;
        cordic_req_t stray_req;
        cordic_res_t held_res;
        int          k;
        int          gap;
        entry     = vectors[idx];
        stray_req = '{mode: CORDIC_VECTOR, angle: 16'h1234, y: 18'h30000};

        @(posedge clk);
        #1;
        req_i   = make_req(entry);
        start_i = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;

        // cycle k lies between edges k-1 and k after the sampling edge
        for (k = 1; k <= DONE_LAT; k++) begin
            if (idx == STRAY_ENTRY && k == STRAY_CYCLE) begin
                @(posedge clk);
                #1;
                req_i   = stray_req;
                start_i = 1'b1;
            end
            if (idx == STRAY_ENTRY && k == STRAY_CYCLE + 1) begin
                @(posedge clk);
                #1;
                req_i   = make_req(entry);
                start_i = 1'b0;
            end
            @(negedge clk);
            if (k < DONE_LAT) begin
                assert (busy_o && !done_o)
                    else begin
                        $display("ERROR: busy_o low or done_o early in cycle %0d of entry %0d",
                                 k, idx);
                        abort_run("handshake timing wrong");
                    end
            end else begin
                assert (done_o && !busy_o)
                    else begin
                        $display("ERROR: done_o not raised %0d cycles after start of entry %0d",
                                 DONE_LAT, idx);
                        abort_run("done timing wrong");
                    end
            end
        end

        if (entry.mode == CORDIC_ROTATE) begin
            check_coord("res_o.sin", res_o.sin, entry.exp_sin);
            check_coord("res_o.cos", res_o.cos, entry.exp_cos);
        end else begin
            check_angle("res_o.angle", res_o.angle, entry.exp_angle);
            check_coord("res_o.sin", res_o.sin, entry.exp_sin);
        end
        held_res = res_o;

        check_idle(held_res);
        if (idx < NUM_VECTORS - 1) begin
            gap = $urandom_range(MAX_GAP, 0);
            repeat (gap) begin
                check_idle(held_res);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("ERROR: run did not end within %0d cycles", CYCLE_LIMIT);
            abort_run("timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk       = 1'b0;
        rst_n_i   = 1'b0;
        start_i   = 1'b0;
        req_i     = '0;
        cycle_cnt = 0;
        void'($urandom(21));
        load_vectors();

        repeat (8) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        @(negedge clk);
        assert (!busy_o && !done_o)
            else begin
                $display("ERROR: busy_o or done_o high after reset");
                abort_run("reset state wrong");
            end
        assert (res_o == '0)
            else begin
                $display("CHECK FAILED: res_o expected 0x%h got 0x%h", cordic_res_t'('0), res_o);
                abort_run("result not cleared by reset");
            end

        for (int idx = 0; idx < NUM_VECTORS; idx++) begin
            apply_entry(idx);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+common
+incdir+verification
common/cordic_pkg.sv
cordic_core/cordic_atan_rom.sv
cordic_core/cordic_micro_rotation.sv
cordic_core/cordic_sequencer.sv
src/cordic_quadrant_map.sv
src/cordic_top.sv
verification/cordic_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the CORDIC testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f verilog.f --top-module cordic_tb \
    -o cordic_tb_sim > build.log 2>&1 \
    && ./obj_dir/cordic_tb_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error, see build.log and sim.log"

grep -qx "TEST RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
